//--- vec_pkg.sv
// Vector element definitions
package vec_pkg;

    localparam int ELEN    = 64;               // Width of one lane slice
    localparam int NUM_SEW = 4;                // Number of supported element widths

    typedef logic [ELEN-1:0] bus64_t;

    // Element width, element bits = 8 << sew
    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    typedef enum logic [4:0] {
        VADD, VSUB, VRSUB,                     // Add group
        VMUL, VMULHU,                          // Plain multiply
        VMACC, VMADD,                          // Multiply then add
        VMIN, VMINU, VMAX, VMAXU,              // Compare group
        VSLL, VSRL, VSRA,                      // Shifts
        VAND, VOR, VXOR,                       // Bitwise
        VID,                                   // Element index
        VMV,                                   // Move vs1
        VNOP                                   // Result is zero
    } vop_t;

endpackage

//--- exec_pkg.sv
// Execution request and response types
package exec_pkg;

    import vec_pkg::*;

    localparam int MAX_LANES = 8;              // Upper bound for NUM_LANES

    // What one lane sees of an instruction
    typedef struct packed {
        logic   valid;
        vop_t   op;
        sew_t   sew;
        bus64_t vs1;
        bus64_t vs2;
        bus64_t vd_old;
    } lane_instr_t;

    // Whole-unit request, lane l owns bits [64*l +: 64]
    typedef struct packed {
        logic                      valid;
        vop_t                      op;
        sew_t                      sew;
        logic [MAX_LANES*ELEN-1:0] vs1;
        logic [MAX_LANES*ELEN-1:0] vs2;
        logic [MAX_LANES*ELEN-1:0] vd_old;
    } exec_req_t;

    typedef struct packed {
        logic                      valid;
        logic [MAX_LANES*ELEN-1:0] vd;         // Unused lanes read zero
    } exec_resp_t;

endpackage

//--- pipe_stage.sv
// Valid-qualified pipeline register
`timescale 1ns/10ps

module pipe_stage #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic valid_i,
    input  T     data_i,
    output logic valid_o,
    output T     data_o
);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                data_o <= data_i;                  // Payload holds during bubbles
            end
        end
    end

endmodule

//--- vaddsub.sv
// Element-partitioned add and subtract
`timescale 1ns/10ps

module vaddsub
    import vec_pkg::*;
(
    input  vop_t   op_i,
    input  sew_t   sew_i,
    input  bus64_t a_i,
    input  bus64_t b_i,
    output bus64_t sum_o
);

    logic sub_ab;
    logic sub_ba;
    bus64_t sum_sew [NUM_SEW];

    assign sub_ab = (op_i == VSUB);
    assign sub_ba = (op_i == VRSUB);

    // One adder set per SEW, each element sized to its width so no carry leaks
    for (genvar s = 0; s < NUM_SEW; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar e = 0; e < ELEN / W; e++) begin : g_elem
            logic [W-1:0] ea;
            logic [W-1:0] eb;

            assign ea = a_i[e*W +: W];
            assign eb = b_i[e*W +: W];
            assign sum_sew[s][e*W +: W] = sub_ab ? ea - eb :
                                          sub_ba ? eb - ea :
                                                   ea + eb;   // VADD, VMACC, VMADD
        end
    end

    assign sum_o = sum_sew[sew_i];

endmodule

//--- vmul.sv
// Registered element-partitioned multiplier
`timescale 1ns/10ps

module vmul
    import vec_pkg::*;
(
    input  logic   clk_i,
    input  logic   rstn_i,
    input  vop_t   op_i,
    input  sew_t   sew_i,
    input  bus64_t a_i,
    input  bus64_t b_i,
    output bus64_t prod_o
);

    logic   take_high;
    bus64_t prod_sew [NUM_SEW];
    bus64_t prod_d;

    assign take_high = (op_i == VMULHU);        // Everything else keeps the low half

    for (genvar s = 0; s < NUM_SEW; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar e = 0; e < ELEN / W; e++) begin : g_elem
            logic [2*W-1:0] full;

            // Operands widen to 2W, unsigned
            assign full = a_i[e*W +: W] * b_i[e*W +: W];
            assign prod_sew[s][e*W +: W] = take_high ? full[2*W-1:W] : full[W-1:0];
        end
    end

    assign prod_d = prod_sew[sew_i];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            prod_o <= '0;
        end else begin
            prod_o <= prod_d;                       // Used in the second stage
        end
    end

endmodule

//--- vcomp.sv
// Element-partitioned min and max
`timescale 1ns/10ps

module vcomp
    import vec_pkg::*;
(
    input  vop_t   op_i,
    input  sew_t   sew_i,
    input  bus64_t a_i,
    input  bus64_t b_i,
    output bus64_t res_o
);

    logic   is_signed;
    logic   want_min;
    bus64_t res_sew [NUM_SEW];

    assign is_signed = (op_i == VMIN) || (op_i == VMAX);
    assign want_min  = (op_i == VMIN) || (op_i == VMINU);

    for (genvar s = 0; s < NUM_SEW; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar e = 0; e < ELEN / W; e++) begin : g_elem
            logic [W-1:0] ea;
            logic [W-1:0] eb;
            logic         a_lt_b;

            assign ea     = a_i[e*W +: W];
            assign eb     = b_i[e*W +: W];
            assign a_lt_b = is_signed ? ($signed(ea) < $signed(eb)) : (ea < eb);
            assign res_sew[s][e*W +: W] = (a_lt_b == want_min) ? ea : eb;   // Ties give b
        end
    end

    assign res_o = res_sew[sew_i];

endmodule

//--- vshift.sv
// Element-partitioned shifts
`timescale 1ns/10ps

module vshift
    import vec_pkg::*;
(
    input  vop_t   op_i,
    input  sew_t   sew_i,
    input  bus64_t a_i,                             // Shift amounts
    input  bus64_t b_i,                             // Data
    output bus64_t res_o
);

    bus64_t res_sew [NUM_SEW];

    for (genvar s = 0; s < NUM_SEW; s++) begin : g_sew
        localparam int W  = 8 << s;
        localparam int SW = $clog2(W);
        for (genvar e = 0; e < ELEN / W; e++) begin : g_elem
            logic [SW-1:0] sh;
            logic [W-1:0]  eb;
            logic [W-1:0]  sra;

            assign sh  = a_i[e*W +: SW];            // Only log2(SEW) bits count
            assign eb  = b_i[e*W +: W];
            assign sra = $signed(eb) >>> sh;        // Kept apart so the sign survives
            assign res_sew[s][e*W +: W] = (op_i == VSLL) ? eb << sh :
                                          (op_i == VSRL) ? eb >> sh :
                                                           sra;
        end
    end

    assign res_o = res_sew[sew_i];

endmodule

//--- functional_unit.sv
// Two-stage vector lane
`timescale 1ns/10ps

module functional_unit
    import vec_pkg::*;
    import exec_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  lane_instr_t instr_i,
    output logic        valid_o,
    output bus64_t      vd_o
);

    lane_instr_t instr_q;
    logic        instr_vld_q;
    logic        stage_b_vld;
    bus64_t      comp_res, shift_res, vid_res, early_d, early_q;
    bus64_t      mul_b, prod_q;
    bus64_t      add_a, add_b, add_sum, result;
    bus64_t      vid_sew [NUM_SEW];

    // VID pattern, element e of lane LANE_ID
    for (genvar s = 0; s < NUM_SEW; s++) begin : g_vid
        localparam int W = 8 << s;
        localparam int N = ELEN / W;
        for (genvar e = 0; e < N; e++) begin : g_elem
            assign vid_sew[s][e*W +: W] = W'(LANE_ID * N + e);
        end
    end
    assign vid_res = vid_sew[instr_i.sew];

    vcomp vcomp_i (.op_i(instr_i.op), .sew_i(instr_i.sew), .a_i(instr_i.vs1),
                   .b_i(instr_i.vs2), .res_o(comp_res));
    vshift vshift_i (.op_i(instr_i.op), .sew_i(instr_i.sew), .a_i(instr_i.vs1),
                     .b_i(instr_i.vs2), .res_o(shift_res));

    always_comb begin
        case (instr_i.op)
            VMIN, VMINU, VMAX, VMAXU: early_d = comp_res;
            VSLL, VSRL, VSRA:         early_d = shift_res;
            VAND:                     early_d = instr_i.vs1 & instr_i.vs2;
            VOR:                      early_d = instr_i.vs1 | instr_i.vs2;
            VXOR:                     early_d = instr_i.vs1 ^ instr_i.vs2;
            VID:                      early_d = vid_res;
            VMV:                      early_d = instr_i.vs1;
            default:                  early_d = '0;       // VNOP and late ops
        endcase
    end

    assign mul_b = (instr_i.op == VMADD) ? instr_i.vd_old : instr_i.vs2;

    vmul vmul_i (.clk_i(clk_i), .rstn_i(rstn_i), .op_i(instr_i.op), .sew_i(instr_i.sew),
                 .a_i(instr_i.vs1), .b_i(mul_b), .prod_o(prod_q));

    pipe_stage #(.T(lane_instr_t)) instr_stage_i (.clk_i(clk_i), .rstn_i(rstn_i),
        .valid_i(instr_i.valid), .data_i(instr_i), .valid_o(instr_vld_q), .data_o(instr_q));
    pipe_stage #(.T(bus64_t)) early_stage_i (.clk_i(clk_i), .rstn_i(rstn_i),
        .valid_i(instr_i.valid), .data_i(early_d), .valid_o(), .data_o(early_q));

    // Instruction register carries the stage B valid
    assign stage_b_vld = instr_vld_q;

    always_comb begin
        case (instr_q.op)
            VMACC: begin
                add_a = prod_q;
                add_b = instr_q.vd_old;
            end
            VMADD: begin
                add_a = prod_q;
                add_b = instr_q.vs2;
            end
            default: begin
                add_a = instr_q.vs1;
                add_b = instr_q.vs2;
            end
        endcase
    end

    vaddsub vaddsub_i (.op_i(instr_q.op), .sew_i(instr_q.sew), .a_i(add_a), .b_i(add_b),
                       .sum_o(add_sum));

    always_comb begin
        case (instr_q.op)
            VADD, VSUB, VRSUB, VMACC, VMADD: result = add_sum;
            VMUL, VMULHU:                    result = prod_q;
            default:                         result = early_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            vd_o    <= '0;
        end else begin
            valid_o <= stage_b_vld;
            if (stage_b_vld) begin
                vd_o <= result;
            end
        end
    end

endmodule

//--- simd_exec_unit.sv
// SIMD execution unit top level
`timescale 1ns/10ps

module simd_exec_unit
    import vec_pkg::*;
    import exec_pkg::*;
#(
    parameter int NUM_LANES = 4                     // 1 to MAX_LANES
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  exec_req_t  req_i,
    output exec_resp_t resp_o
);

    logic [NUM_LANES-1:0] lane_vld;
    bus64_t               lane_vd [NUM_LANES];

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_instr_t instr;

        // Every lane runs the same opcode on its own 64-bit slice
        assign instr.valid  = req_i.valid;
        assign instr.op     = req_i.op;
        assign instr.sew    = req_i.sew;
        assign instr.vs1    = req_i.vs1[l*ELEN +: ELEN];
        assign instr.vs2    = req_i.vs2[l*ELEN +: ELEN];
        assign instr.vd_old = req_i.vd_old[l*ELEN +: ELEN];

        functional_unit #(.LANE_ID(l)) fu_i (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .instr_i (instr),
            .valid_o (lane_vld[l]),
            .vd_o    (lane_vd[l])
        );
    end

    always_comb begin
        resp_o       = '0;                          // Lanes past NUM_LANES stay zero
        resp_o.valid = lane_vld[0];                 // All lanes share one timing
        for (int l = 0; l < NUM_LANES; l++) begin
            resp_o.vd[l*ELEN +: ELEN] = lane_vd[l];
        end
    end

endmodule

//--- simd_exec_unit_properties.sv
// Top-level valid timing checks
`timescale 1ns/10ps

module simd_exec_unit_properties
    import exec_pkg::*;
(
    input logic       clk_i,
    input logic       rstn_i,
    input exec_req_t  req_i,
    input exec_resp_t resp_o
);

    a_idle_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !resp_o.valid)
        else $error("resp_o.valid high while reset is held");

    // Pipeline registers clear on reset
    a_zero_in_reset: assert property (@(posedge clk_i) !rstn_i |-> (resp_o.vd == '0))
        else $error("resp_o.vd not zero while reset is held");

    a_two_cycles: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_o.valid == $past(req_i.valid, 2))
        else $error("resp_o.valid does not follow req_i.valid by two cycles");

endmodule

bind simd_exec_unit simd_exec_unit_properties props_i (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .req_i  (req_i),
    .resp_o (resp_o)
);

//--- tb_simd_exec_unit.sv
// SIMD execution unit testbench
`timescale 1ns/10ps

module tb_simd_exec_unit
    import vec_pkg::*;
    import exec_pkg::*;
();

    localparam int NUM_LANES    = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 54;
    localparam int TIMEOUT      = NUM_ROWS + RESET_CYCLES + 20;

    typedef struct packed {
        logic       valid;
        vop_t       op;
        sew_t       sew;
        logic [7:0] seed;                           // Bit 7 picks boundary operands
    } row_t;

    // Carry, borrow and sign boundary words, index from seed bits [1:0] and [3:2]
    localparam bus64_t CORNER [4] = '{64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101,
                                      64'h8080_8080_8080_8080, 64'h7f7f_7f7f_7f7f_7f7f};
    localparam row_t IDLE_ROW = '{1'b0, VNOP, SEW_8, 8'h00};
    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, VADD, SEW_8, 8'h84}, '{1'b1, VADD, SEW_16, 8'h84}, '{1'b1, VADD, SEW_32, 8'h84},
        '{1'b1, VADD, SEW_64, 8'h84}, '{1'b1, VADD, SEW_8, 8'h11}, '{1'b1, VADD, SEW_32, 8'h12},
        '{1'b1, VSUB, SEW_8, 8'h81}, '{1'b1, VSUB, SEW_16, 8'h81}, '{1'b1, VSUB, SEW_32, 8'h81},
        '{1'b1, VSUB, SEW_64, 8'h81}, '{1'b1, VRSUB, SEW_8, 8'h84}, '{1'b1, VRSUB, SEW_16, 8'h13},
        '{1'b1, VRSUB, SEW_32, 8'h14}, '{1'b1, VRSUB, SEW_64, 8'h84}, '{1'b0, VADD, SEW_8, 8'h15},
        '{1'b1, VMUL, SEW_8, 8'h21}, '{1'b1, VMUL, SEW_16, 8'h22}, '{1'b1, VMUL, SEW_32, 8'h23},
        '{1'b1, VMUL, SEW_64, 8'h24}, '{1'b1, VMULHU, SEW_8, 8'h25}, '{1'b1, VMULHU, SEW_16, 8'h26},
        '{1'b1, VMULHU, SEW_32, 8'h27}, '{1'b1, VMULHU, SEW_64, 8'h80}, '{1'b1, VMACC, SEW_8, 8'h28},
        '{1'b1, VMACC, SEW_32, 8'h29}, '{1'b1, VMADD, SEW_16, 8'h2a}, '{1'b1, VMADD, SEW_64, 8'h2b},
        '{1'b1, VMIN, SEW_8, 8'h8e}, '{1'b1, VMIN, SEW_32, 8'h31}, '{1'b1, VMINU, SEW_16, 8'h8b},
        '{1'b1, VMINU, SEW_64, 8'h32}, '{1'b1, VMAX, SEW_16, 8'h8e}, '{1'b1, VMAX, SEW_64, 8'h8b},
        '{1'b1, VMAXU, SEW_8, 8'h8e}, '{1'b1, VMAXU, SEW_32, 8'h33}, '{1'b0, VMUL, SEW_8, 8'h34},
        '{1'b1, VSLL, SEW_8, 8'h88}, '{1'b1, VSLL, SEW_64, 8'h41}, '{1'b1, VSRL, SEW_16, 8'h88},
        '{1'b1, VSRL, SEW_32, 8'h42}, '{1'b1, VSRA, SEW_8, 8'h88}, '{1'b1, VSRA, SEW_64, 8'h88},
        '{1'b1, VAND, SEW_8, 8'h51}, '{1'b1, VOR, SEW_16, 8'h52}, '{1'b1, VXOR, SEW_32, 8'h53},
        '{1'b1, VID, SEW_8, 8'h00}, '{1'b1, VID, SEW_16, 8'h00}, '{1'b1, VID, SEW_32, 8'h00},
        '{1'b1, VID, SEW_64, 8'h00}, '{1'b1, VMV, SEW_64, 8'h54}, '{1'b1, VNOP, SEW_8, 8'h55},
        '{1'b1, VSRA, SEW_32, 8'h43}, '{1'b0, VSUB, SEW_16, 8'h00}, '{1'b1, VADD, SEW_16, 8'h56}
    };

    logic        clk_i;
    logic        rstn_i;
    exec_req_t   req_i;
    exec_resp_t  resp_o;
    logic [31:0] lcg_state;
    int          cycles = 0;
    exec_resp_t  exp_q [$];                         // One entry per cycle, two in flight

    simd_exec_unit #(.NUM_LANES(NUM_LANES)) dut_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (req_i),
        .resp_o (resp_o)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bus64_t rand_word();
        bus64_t w;
        lcg_state = lcg_next(lcg_state);
        w[63:32] = lcg_state;
        lcg_state = lcg_next(lcg_state);
        w[31:0] = lcg_state;
        return w;
    endfunction

    // One element of width w, operands in the low bits
    function automatic bus64_t ref_elem(vop_t op, int w, bus64_t a, bus64_t b, bus64_t c,
                                        bus64_t idx);
        bus64_t       mask;
        bus64_t       r;
        logic [127:0] full;
        longint       sa;
        longint       sb;
        int           sh;
        mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
        a = a & mask;
        b = b & mask;
        c = c & mask;
        sa = $signed(a << (64 - w)) >>> (64 - w);  // Sign extend from bit w-1
        sb = $signed(b << (64 - w)) >>> (64 - w);
        sh = int'(a[5:0]) & (w - 1);
        full = {64'd0, a} * {64'd0, b};
        case (op)
            VADD:    r = a + b;
            VSUB:    r = a - b;
            VRSUB:   r = b - a;
            VMUL:    r = a * b;
            VMULHU:  r = bus64_t'(full >> w);
            VMACC:   r = a * b + c;
            VMADD:   r = a * c + b;
            VMIN:    r = (sa < sb) ? a : b;
            VMINU:   r = (a < b) ? a : b;
            VMAX:    r = (sa > sb) ? a : b;
            VMAXU:   r = (a > b) ? a : b;
            VSLL:    r = b << sh;
            VSRL:    r = b >> sh;
            VSRA:    r = bus64_t'(sb >>> sh);
            VAND:    r = a & b;
            VOR:     r = a | b;
            VXOR:    r = a ^ b;
            VID:     r = idx;
            VMV:     r = a;
            default: r = '0;
        endcase
        return r & mask;
    endfunction

    function automatic bus64_t ref_lane(row_t row, bus64_t a, bus64_t b, bus64_t c, int lane);
        int     w;
        int     n;
        bus64_t r;
        bus64_t el;
        w = 8 << row.sew;
        n = 64 / w;
        r = '0;
        for (int e = 0; e < n; e++) begin
            el = ref_elem(row.op, w, a >> (e * w), b >> (e * w), c >> (e * w),
                          bus64_t'(lane * n + e));
            r = r | (el << (e * w));
        end
        return r;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_valid(logic got, logic want);
        if (got !== want) begin
            fail_run($sformatf("Mismatch resp_o.valid: got %0h, expected %0h", got, want));
        end
    endtask

    task automatic check_vd(int lane, bus64_t got, bus64_t want);
        if (got !== want) begin
            fail_run($sformatf("Mismatch resp_o.vd lane %0d: got %016h, expected %016h",
                               lane, got, want));
        end
    endtask

    task automatic check_resp(exec_resp_t want);
        check_valid(resp_o.valid, want.valid);
        if (want.valid) begin                       // vd holds its last value in bubbles
            for (int l = 0; l < MAX_LANES; l++) begin
                check_vd(l, resp_o.vd[l*ELEN +: ELEN], want.vd[l*ELEN +: ELEN]);
            end
        end
    endtask

    task automatic apply_row(row_t row);
        exec_resp_t want;
        bus64_t     a;
        bus64_t     b;
        bus64_t     c;
        lcg_state = lcg_state ^ {24'd0, row.seed};
        req_i = '0;
        want = '0;
        req_i.valid = row.valid;
        req_i.op = row.op;
        req_i.sew = row.sew;
        for (int l = 0; l < MAX_LANES; l++) begin
            a = row.seed[7] ? CORNER[row.seed[1:0]] : rand_word();
            b = row.seed[7] ? CORNER[row.seed[3:2]] : rand_word();
            c = rand_word();
            req_i.vs1[l*ELEN +: ELEN] = a;          // Unused lanes get data too
            req_i.vs2[l*ELEN +: ELEN] = b;
            req_i.vd_old[l*ELEN +: ELEN] = c;
            if (l < NUM_LANES) begin
                want.vd[l*ELEN +: ELEN] = ref_lane(row, a, b, c, l);
            end
        end
        want.valid = row.valid;
        exp_q.push_back(want);
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            fail_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        exec_resp_t idle;
        idle = '0;
        rstn_i = 1'b0;
        req_i = '0;
        lcg_state = 32'h9f54484e;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk_i);
            check_valid(resp_o.valid, 1'b0);
        end
        rstn_i = 1'b1;
        exp_q.push_back(idle);                      // First two cycles after reset
        exp_q.push_back(idle);
        for (int i = 0; i < NUM_ROWS + 2; i++) begin
            @(negedge clk_i);
            check_resp(exp_q.pop_front());          // Request from two cycles back
            if (i < NUM_ROWS) begin
                apply_row(ROWS[i]);
            end else begin
                apply_row(IDLE_ROW);
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- sources.f
vec_pkg.sv
exec_pkg.sv
pipe_stage.sv
vaddsub.sv
vmul.sv
vcomp.sv
vshift.sv
functional_unit.sv
simd_exec_unit.sv
simd_exec_unit_properties.sv
tb_simd_exec_unit.sv

//--- Makefile
# Verilator build and run for the SIMD execution unit
VERILATOR ?= verilator
TOP       ?= tb_simd_exec_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(EXE)
	./$(EXE)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
